/* flist.f */
+incdir+rtl
rtl/fetchPkg.sv
rtl/memBus.sv
rtl/cacheArray.sv
rtl/missController.sv
rtl/mainMemory.sv
rtl/fetchCache.sv
test/fetchCache_properties.sv
test/fetchCache_tb.sv

/* rtl/cacheArray.sv */
`timescale 1ns/100ps
// Cache array
// Eight fully associative one-word entries with parallel tag compare and round-robin fill
`include "fetchCache_config.svh"

module cacheArray (
    input  logic           clk,
    input  logic           RESET,
    input  logic           flush,
    input  fetchPkg::addrT lookupAddr,
    output logic           hit,
    output logic [31:0]    hitData,
    input  logic           fillValid,
    input  fetchPkg::fillT fill
);

    fetchPkg::entryT             entries [`FC_ENTRIES];
    logic [`FC_PTR_W-1:0]        victimPtr;
    logic [`FC_ENTRIES-1:0]      matchVec;

    // Parallel compare against every entry
    always_comb begin
        for (int i = 0; i < `FC_ENTRIES; i++) begin
            matchVec[i] = entries[i].valid && (entries[i].tag == lookupAddr.tag);
        end
    end

    // At most one entry matches, since fills only happen on a miss
    always_comb begin
        hit     = |matchVec;
        hitData = '0;
        for (int i = 0; i < `FC_ENTRIES; i++) begin
            if (matchVec[i]) begin
                hitData = hitData | entries[i].data;
            end
        end
    end

    // Entry fill, valid bits and victim pointer
    always_ff @(posedge clk) begin
        if (!RESET) begin
            victimPtr <= '0;
            for (int i = 0; i < `FC_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (flush) begin
            victimPtr <= '0;  // Replacement restarts at entry 0
            for (int i = 0; i < `FC_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (fillValid) begin
            entries[victimPtr].valid <= 1'b1;
            entries[victimPtr].tag   <= fill.tag;
            entries[victimPtr].data  <= fill.data;
            if (victimPtr == `FC_PTR_W'(`FC_ENTRIES - 1)) begin
                victimPtr <= '0;
            end else begin
                victimPtr <= victimPtr + 1'b1;
            end
        end
    end

endmodule

/* rtl/fetchCache.sv */
`timescale 1ns/100ps
// Instruction fetch cache top
// Cache array, miss controller and main memory joined by the memory bus
`include "fetchCache_config.svh"

module fetchCache (
    input  logic                 clk,
    input  logic                 RESET,
    input  logic                 flush,
    input  logic                 fetchReq,
    input  logic [31:0]          fetchAddr,
    output logic                 fetchAck,
    output logic [31:0]          fetchData,
    input  logic                 loadEn,
    input  logic [31:0]          loadAddr,
    input  logic [31:0]          loadData,
    output logic [`FC_CNT_W-1:0] hitCount,
    output logic [`FC_CNT_W-1:0] missCount
);

    fetchPkg::addrT addr;
    logic           hit;
    logic [31:0]    hitData;
    logic           fillValid;
    fetchPkg::fillT fill;

    assign addr = fetchPkg::addrT'(fetchAddr);

    memBus bus ();

    // Compare runs on the live address, stable while fetchReq is high
    cacheArray i_cacheArray (
        .clk       (clk),
        .RESET     (RESET),
        .flush     (flush),
        .lookupAddr(addr),
        .hit       (hit),
        .hitData   (hitData),
        .fillValid (fillValid),
        .fill      (fill)
    );

    missController i_missController (
        .clk      (clk),
        .RESET    (RESET),
        .fetchReq (fetchReq),
        .fetchAddr(addr),
        .fetchAck (fetchAck),
        .fetchData(fetchData),
        .hit      (hit),
        .hitData  (hitData),
        .fillValid(fillValid),
        .fill     (fill),
        .mem      (bus.requester),
        .hitCount (hitCount),
        .missCount(missCount)
    );

    mainMemory i_mainMemory (
        .clk     (clk),
        .RESET   (RESET),
        .loadEn  (loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .bus     (bus.responder)
    );

endmodule

/* rtl/fetchCache_config.svh */
// Fetch cache sizing
// Entry count, memory geometry and counter width

`ifndef FETCHCACHE_CONFIG_SVH
`define FETCHCACHE_CONFIG_SVH

// Fully associative entries and victim pointer width
`define FC_ENTRIES 8
`define FC_PTR_W 3

// Main memory words, indexed by low word address bits
`define FC_MEM_DEPTH 256

// Edges from req sampled high to ack
`define FC_MEM_LATENCY 3

// Hit and miss counters, wrapping
`define FC_CNT_W 16

`endif

/* rtl/fetchPkg.sv */
// Fetch cache types
// Address split, cache entry layout and fill record shared by the cache blocks

package fetchPkg;

    // Byte address seen as word tag plus byte offset
    typedef struct packed {
        logic [29:0] tag;     // Word address, bits 31 down to 2
        logic [1:0]  offset;  // Byte within word, ignored
    } addrT;

    // One cache entry holding a single word
    typedef struct packed {
        logic        valid;
        logic [29:0] tag;
        logic [31:0] data;
    } entryT;

    // Word written into the victim entry when a miss completes
    typedef struct packed {
        logic [29:0] tag;
        logic [31:0] data;
    } fillT;

endpackage

/* rtl/mainMemory.sv */
`timescale 1ns/100ps
// Main memory
// Loadable word array answering the memory bus after a fixed latency
`include "fetchCache_config.svh"

module mainMemory (
    input  logic        clk,
    input  logic        RESET,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    memBus.responder    bus
);

    localparam int idxW = $clog2(`FC_MEM_DEPTH);
    localparam int latW = $clog2(`FC_MEM_LATENCY + 1);

    logic [31:0]     words [`FC_MEM_DEPTH];
    logic [latW-1:0] waitCnt;
    logic            ready;

    // Latency reached on this cycle
    assign ready = bus.req && !bus.ack && (waitCnt == latW'(`FC_MEM_LATENCY));

    // Load port, byte address with upper bits ignored
    always_ff @(posedge clk) begin
        if (loadEn) begin
            words[loadAddr[idxW+1:2]] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (!RESET) begin
            bus.ack <= 1'b0;
            waitCnt <= '0;
        end else if (!bus.req) begin
            bus.ack <= 1'b0;  // Falls one edge after req
            waitCnt <= '0;
        end else if (ready) begin
            bus.ack <= 1'b1;
        end else if (!bus.ack) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // Read word, held while ack is high
    always_ff @(posedge clk) begin
        if (ready) begin
            bus.data <= words[bus.addr[idxW+1:2]];
        end
    end

endmodule

/* rtl/memBus.sv */
`timescale 1ns/100ps
// Memory bus
// Four-phase req/ack link between miss controller and main memory

interface memBus;
    logic        req;   // Held high until ack seen
    logic        ack;   // High while data is valid
    logic [31:0] addr;  // Byte address, stable while req high
    logic [31:0] data;

    modport requester (
        output req,
        output addr,
        input  ack,
        input  data
    );

    modport responder (
        input  req,
        input  addr,
        output ack,
        output data
    );
endinterface

/* rtl/missController.sv */
`timescale 1ns/100ps
// Miss controller
// Processor-side handshake FSM, hit/miss counters and memory fetch on a miss
`include "fetchCache_config.svh"

module missController (
    input  logic                 clk,
    input  logic                 RESET,
    input  logic                 fetchReq,
    input  fetchPkg::addrT       fetchAddr,
    output logic                 fetchAck,
    output logic [31:0]          fetchData,
    input  logic                 hit,
    input  logic [31:0]          hitData,
    output logic                 fillValid,
    output fetchPkg::fillT       fill,
    memBus.requester             mem,
    output logic [`FC_CNT_W-1:0] hitCount,
    output logic [`FC_CNT_W-1:0] missCount
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        ACK,
        WAIT_DROP
    } stateT;

    stateT          state;
    fetchPkg::addrT addrQ;  // Request address, held for the fill

    // Fill lands on the same edge that takes the memory word
    assign fillValid = (state == MEM_WAIT) && mem.ack;
    assign fill      = '{tag: addrQ.tag, data: mem.data};

    always_ff @(posedge clk) begin
        if (!RESET) begin
            state     <= IDLE;
            fetchAck  <= 1'b0;
            mem.req   <= 1'b0;
            hitCount  <= '0;
            missCount <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fetchReq) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) begin
                        hitCount <= hitCount + 1'b1;
                        state    <= ACK;
                    end else begin
                        missCount <= missCount + 1'b1;
                        mem.req   <= 1'b1;  // Start memory handshake
                        state     <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (mem.ack) begin
                        mem.req  <= 1'b0;
                        fetchAck <= 1'b1;
                        state    <= WAIT_DROP;
                    end
                end
                ACK: begin
                    fetchAck <= 1'b1;
                    state    <= WAIT_DROP;
                end
                WAIT_DROP: begin
                    // Requester may hold req as long as it likes
                    if (!fetchReq) begin
                        fetchAck <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and returned word
    always_ff @(posedge clk) begin
        if (state == IDLE && fetchReq) addrQ <= fetchAddr;
        if (state == LOOKUP && !hit) mem.addr <= addrQ;
        if (state == LOOKUP && hit) fetchData <= hitData;
        if (state == MEM_WAIT && mem.ack) fetchData <= mem.data;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module fetchCache_tb -o simv
./obj_dir/simv 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* test/fetchCache_properties.sv */
`timescale 1ns/100ps
// Handshake properties
// Bound into the miss controller to watch both four-phase handshakes and reset

module fetchCache_properties (
    input logic        clk,
    input logic        RESET,
    input logic        fetchReq,
    input logic        fetchAck,
    input logic [31:0] fetchData,
    input logic        fillValid,
    input logic        memReq,
    input logic        memAck,
    input logic [31:0] memAddr
);

    // Both request lines low once reset has been seen
    resetLow: assert property (@(posedge clk) !RESET |=> !fetchAck && !memReq)
        else $error("fetchAck or memory req high after a reset cycle");

    fetchAckNeedsReq: assert property (@(posedge clk) disable iff (!RESET)
        $rose(fetchAck) |-> $past(fetchReq))
        else $error("fetchAck rose without fetchReq");

    memAckNeedsReq: assert property (@(posedge clk) disable iff (!RESET)
        $rose(memAck) |-> $past(memReq))
        else $error("memory ack rose without memory req");

    memAddrHeld: assert property (@(posedge clk) disable iff (!RESET)
        memReq |=> !memReq || $stable(memAddr))
        else $error("memory addr changed while req was high");

    fetchDataHeld: assert property (@(posedge clk) disable iff (!RESET)
        fetchAck |=> !fetchAck || $stable(fetchData))
        else $error("fetchData changed while fetchAck was high");

    fillOneCycle: assert property (@(posedge clk) disable iff (!RESET)
        fillValid |=> !fillValid)
        else $error("fillValid lasted more than one cycle");

endmodule

bind missController fetchCache_properties i_props (
    .clk      (clk),
    .RESET    (RESET),
    .fetchReq (fetchReq),
    .fetchAck (fetchAck),
    .fetchData(fetchData),
    .fillValid(fillValid),
    .memReq   (mem.req),
    .memAck   (mem.ack),
    .memAddr  (mem.addr)
);

/* test/fetchCache_tb.sv */
`timescale 1ns/100ps
// Fetch cache testbench
// LFSR driven fetches checked against a reference model of the cache
`include "fetchCache_config.svh"

module fetchCache_tb;

    localparam int clkPeriod    = 40;
    localparam int poolSize     = 12;
    localparam int randFetches  = 300;
    localparam int totalFetches = randFetches + 40;
    // Worst fetch: lookup, memory round trip, longest hold, drop
    localparam int fetchCycles  = 4 + `FC_MEM_LATENCY + 7 + 2;
    localparam int runCycles    = 5 + `FC_MEM_DEPTH + totalFetches * fetchCycles;

    logic                 clk = 1'b0;
    logic                 RESET;
    logic                 flush;
    logic                 fetchReq;
    logic [31:0]          fetchAddr;
    logic                 fetchAck;
    logic [31:0]          fetchData;
    logic                 loadEn;
    logic [31:0]          loadAddr;
    logic [31:0]          loadData;
    logic [`FC_CNT_W-1:0] hitCount;
    logic [`FC_CNT_W-1:0] missCount;

    logic [31:0]          lfsr = 32'd28;
    logic [29:0]          pool [poolSize];
    logic [31:0]          memCopy [`FC_MEM_DEPTH];  // Model of main memory
    logic [29:0]          modelTag [`FC_ENTRIES];
    logic                 modelValid [`FC_ENTRIES];
    int                   modelPtr;
    logic [`FC_CNT_W-1:0] expHits;
    logic [`FC_CNT_W-1:0] expMisses;
    logic                 outcome;
    logic [31:0]          r;
    int                   idx;

    fetchCache i_dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int findEntry(input logic [29:0] tag);
        int slot;
        slot = -1;
        for (int i = 0; i < `FC_ENTRIES; i++) begin
            if (modelValid[i] && modelTag[i] == tag) slot = i;
        end
        return slot;
    endfunction

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic showMismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("Mismatch %s: expected %h, got %h", name, exp, got);
        abortRun();
    endtask

    task automatic showProblem(input string msg);
        $display("Error: %s", msg);
        abortRun();
    endtask

    // One four-phase fetch, entered and left on a falling edge
    task automatic doFetch(input logic [29:0] tag, output logic wasHit);
        logic [31:0]          expData;
        logic [31:0]          bits;
        logic [`FC_CNT_W-1:0] hitsBefore;
        int                   slot;
        int                   waited;
        slot       = findEntry(tag);
        expData    = memCopy[tag[$clog2(`FC_MEM_DEPTH)-1:0]];
        bits       = randBits(2);
        hitsBefore = hitCount;
        fetchAddr  = {tag, bits[1:0]};  // Byte offset must not matter
        fetchReq   = 1'b1;
        waited     = 0;
        while (fetchAck !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        wasHit = (hitCount != hitsBefore);
        if (slot >= 0) begin
            expHits++;
        end else begin
            expMisses++;
            modelTag[modelPtr]   = tag;
            modelValid[modelPtr] = 1'b1;
            modelPtr             = (modelPtr + 1) % `FC_ENTRIES;
        end
        assert (fetchData === expData) else showMismatch("fetchData", expData, fetchData);
        assert (hitCount === expHits) else showMismatch("hitCount", 32'(expHits), 32'(hitCount));
        assert (missCount === expMisses)
            else showMismatch("missCount", 32'(expMisses), 32'(missCount));
        // Sampling edge plus two more, so ack is seen on the third falling edge
        assert (slot < 0 || waited == 3)
            else showProblem($sformatf("hit acknowledged after %0d cycles, not 2", waited - 1));
        bits = randBits(3);
        repeat (bits[2:0]) begin
            @(negedge clk);
            assert (fetchAck === 1'b1) else showProblem("fetchAck fell while fetchReq was high");
            assert (fetchData === expData) else showMismatch("fetchData", expData, fetchData);
        end
        fetchReq = 1'b0;
        @(negedge clk);
        assert (fetchAck === 1'b0) else showProblem("fetchAck still high one edge after drop");
    endtask

    initial begin
        RESET     = 1'b0;
        flush     = 1'b0;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        modelPtr  = 0;
        expHits   = '0;
        expMisses = '0;
        for (int i = 0; i < `FC_ENTRIES; i++) modelValid[i] = 1'b0;
        repeat (5) @(negedge clk);
        RESET = 1'b1;
        assert (fetchAck === 1'b0) else showMismatch("fetchAck", 32'd0, 32'(fetchAck));
        assert (hitCount === '0) else showMismatch("hitCount", 32'd0, 32'(hitCount));
        assert (missCount === '0) else showMismatch("missCount", 32'd0, 32'(missCount));

        for (int i = 0; i < `FC_MEM_DEPTH; i++) begin
            memCopy[i] = randBits(32);
            loadEn     = 1'b1;
            loadAddr   = 32'(i) << 2;
            loadData   = memCopy[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        for (int i = 0; i < poolSize; i++) begin
            r       = randBits(26);
            pool[i] = {r[25:0], 4'(i)};  // Low bits keep pool tags distinct
        end

        doFetch(pool[0], outcome);
        assert (outcome === 1'b0) else showMismatch("hit", 32'd0, 32'(outcome));
        doFetch(pool[0], outcome);
        assert (outcome === 1'b1) else showMismatch("hit", 32'd1, 32'(outcome));
        for (int i = 1; i < poolSize; i++) doFetch(pool[i], outcome);
        // pool[0] was the first victim, pool[7] is still resident
        doFetch(pool[0], outcome);
        assert (outcome === 1'b0) else showMismatch("hit", 32'd0, 32'(outcome));
        doFetch(pool[7], outcome);
        assert (outcome === 1'b1) else showMismatch("hit", 32'd1, 32'(outcome));

        repeat (randFetches) begin
            r   = randBits(8);
            idx = int'(r % 32'(poolSize));
            doFetch(pool[idx], outcome);
        end

        // Victim pointer must be away from entry 0 before the flush
        if (modelPtr == 0) begin
            idx = 0;
            while (findEntry(pool[idx]) >= 0) idx++;
            doFetch(pool[idx], outcome);
        end
        assert (i_dut.i_cacheArray.victimPtr === `FC_PTR_W'(modelPtr))
            else showMismatch("victimPtr", 32'(modelPtr), 32'(i_dut.i_cacheArray.victimPtr));

        flush = 1'b1;
        @(negedge clk);
        flush    = 1'b0;
        modelPtr = 0;
        for (int i = 0; i < `FC_ENTRIES; i++) modelValid[i] = 1'b0;
        assert (i_dut.i_cacheArray.victimPtr === '0)
            else showMismatch("victimPtr", 32'd0, 32'(i_dut.i_cacheArray.victimPtr));
        for (int i = 0; i < poolSize; i++) begin
            doFetch(pool[i], outcome);
            assert (outcome === 1'b0) else showMismatch("hit", 32'd0, 32'(outcome));
        end
        doFetch(pool[4], outcome);  // Entries 4 to 7 hold pool[4] to pool[7]
        assert (outcome === 1'b1) else showMismatch("hit", 32'd1, 32'(outcome));

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(2 * runCycles * clkPeriod);
        $display("Timeout: run did not finish within %0d cycles", 2 * runCycles);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
